// ==== regfile_top.f ====
source/rf_pkg.sv
source/int_reg_file.sv
source/csr_file.sv
source/debug_apb_ctrl.sv
source/regfile_top.sv
tests/tb_regfile_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_regfile_top -f regfile_top.f \
  && ./obj_dir/Vtb_regfile_top 2>&1 | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }

# Any failing check leaves its line in the log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation finished without failures"
exit 0

// ==== source/csr_file.sv ====
module csr_file import rf_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  csr_addr_t csr_addr,
  input  logic      csr_we,
  input  word_t     csr_wdata,
  input  logic      trap_valid,
  input  word_t     trap_pc,
  input  word_t     trap_cause,
  input  logic      mret,
  input  csr_addr_t dbg_csr_addr,
  input  logic      dbg_csr_we,
  input  word_t     dbg_wdata,
  output word_t     csr_rdata,
  output word_t     dbg_csr_rdata,
  output logic      dbg_csr_valid,
  output logic      csr_busy,
  output word_t     mtvec_out,
  output logic      mie_out
);

  word_t mstatus;
  word_t mtvec;
  word_t mscratch;
  word_t mepc;
  word_t mcause;

  logic      wr_en;
  csr_addr_t wr_addr;
  word_t     wr_data;

  // Unimplemented addresses read as zero
  function automatic word_t read_csr(input csr_addr_t addr);
    word_t val;
    val = '0;
    case (addr)
      CSR_MSTATUS:  val = mstatus;
      CSR_MTVEC:    val = mtvec;
      CSR_MSCRATCH: val = mscratch;
      CSR_MEPC:     val = mepc;
      CSR_MCAUSE:   val = mcause;
      default:      val = '0;
    endcase
    return val;
  endfunction

  always_comb begin
    csr_rdata     = read_csr(csr_addr);
    dbg_csr_rdata = read_csr(dbg_csr_addr);
  end

  assign dbg_csr_valid = dbg_csr_addr inside {CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH,
                                              CSR_MEPC, CSR_MCAUSE};

  // Anything the core does to the CSRs this cycle
  assign csr_busy = csr_we || trap_valid || mret;

  // Debug writes only arrive when the core is idle, so one write path
  assign wr_en   = csr_we || dbg_csr_we;
  assign wr_addr = csr_we ? csr_addr : dbg_csr_addr;
  assign wr_data = csr_we ? csr_wdata : dbg_wdata;

  assign mtvec_out = mtvec;
  assign mie_out   = mstatus[MSTATUS_MIE];

  always_ff @(posedge clk) begin
    if (reset) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (trap_valid) begin
      // Trap entry overrides a CSR write in the same cycle
      mepc                  <= {trap_pc[31:2], 2'b00};
      mcause                <= trap_cause;
      mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
      mstatus[MSTATUS_MIE]  <= 1'b0;
    end else if (mret) begin
      mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
      mstatus[MSTATUS_MPIE] <= 1'b1;
    end else if (wr_en) begin
      case (wr_addr)
        CSR_MSTATUS:  mstatus  <= wr_data & MSTATUS_WMASK;
        CSR_MTVEC:    mtvec    <= {wr_data[31:2], 2'b00};
        CSR_MSCRATCH: mscratch <= wr_data;
        CSR_MEPC:     mepc     <= {wr_data[31:2], 2'b00};
        CSR_MCAUSE:   mcause   <= wr_data;
        default:      ;
      endcase
    end
  end

  // The trap logic upstream never raises both at once
  a_trap_mret_excl: assert property (
    @(posedge clk) disable iff (reset)
    !(trap_valid && mret)
  );

endmodule

// ==== source/debug_apb_ctrl.sv ====
module debug_apb_ctrl import rf_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  word_t     pwdata,
  input  word_t     dbg_gpr_rdata,
  input  word_t     dbg_csr_rdata,
  input  logic      dbg_csr_valid,
  input  logic      gpr_busy,
  input  logic      csr_busy,
  output logic      pready,
  output word_t     prdata,
  output logic      pslverr,
  output reg_idx_t  dbg_gpr_idx,
  output csr_addr_t dbg_csr_addr,
  output logic      dbg_gpr_we,
  output logic      dbg_csr_we,
  output word_t     dbg_wdata
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    DONE
  } state_e;

  state_e      state;
  apb_target_e target;
  logic        misaligned;
  logic        gpr_out_of_range;
  logic        err;
  logic        target_busy;
  logic        access;

  // Word addresses inside each window
  assign dbg_gpr_idx  = paddr[6:2];
  assign dbg_csr_addr = paddr[13:2];
  assign dbg_wdata    = pwdata;

  always_comb begin
    target = NONE;
    if (paddr[15:7] == APB_GPR_BASE[15:7]) begin
      target = GPR;
    end else if (paddr[15:14] == APB_CSR_BASE[15:14]) begin
      target = CSR;
    end
  end

  assign misaligned       = paddr[1:0] != 2'b00;
  assign gpr_out_of_range = 32'(dbg_gpr_idx) >= NUM_REGS;

  assign err = misaligned || (target == NONE) ||
               ((target == GPR) && gpr_out_of_range) ||
               ((target == CSR) && !dbg_csr_valid);

  // Core updates to the same file win
  always_comb begin
    case (target)
      GPR:     target_busy = gpr_busy;
      CSR:     target_busy = csr_busy;
      default: target_busy = 1'b0;
    endcase
  end

  assign access = (state == ACCESS) && psel && penable;

  // Reads and errors finish at once, writes wait for a free file
  assign pready  = access && (!pwrite || err || !target_busy);
  assign pslverr = pready && err;

  assign dbg_gpr_we = pready && pwrite && !err && (target == GPR);
  assign dbg_csr_we = pready && pwrite && !err && (target == CSR);

  always_comb begin
    prdata = '0;
    if (pready && !pwrite && !err) begin
      prdata = (target == CSR) ? dbg_csr_rdata : dbg_gpr_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (psel && !penable) begin
            state <= ACCESS;
          end
        end
        ACCESS: begin
          if (pready) begin
            state <= DONE;
          end
        end
        // Wait for the master to drop penable before the next setup
        DONE: begin
          if (!(psel && penable)) begin
            state <= psel ? ACCESS : IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Completion only after a proper setup phase
  a_pready_access: assert property (
    @(posedge clk) disable iff (reset)
    pready |-> psel && penable && $past(psel)
  );

endmodule

// ==== source/int_reg_file.sv ====
module int_reg_file import rf_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     rd_we,
  input  word_t    rd_data,
  input  logic     csr_op,
  input  word_t    csr_rdata,
  input  reg_idx_t dbg_gpr_idx,
  input  logic     dbg_gpr_we,
  input  word_t    dbg_wdata,
  output word_t    operand1,
  output word_t    operand2,
  output word_t    dbg_gpr_rdata,
  output logic     gpr_busy
);

  localparam int IDX_W = $clog2(NUM_REGS);

  word_t regs [NUM_REGS];

  logic [IDX_W-1:0] rs1_idx;
  logic [IDX_W-1:0] rs2_idx;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] dbg_idx;
  logic             bypass1;
  logic             bypass2;
  word_t            rs2_val;

  // RV32E only decodes the low four index bits
  assign rs1_idx = rs1[IDX_W-1:0];
  assign rs2_idx = rs2[IDX_W-1:0];
  assign rd_idx  = rd[IDX_W-1:0];
  assign dbg_idx = dbg_gpr_idx[IDX_W-1:0];

  // Forward the write-back value, never for x0
  assign bypass1 = rd_we && (rd_idx != '0) && (rs1_idx == rd_idx);
  assign bypass2 = rd_we && (rd_idx != '0) && (rs2_idx == rd_idx);

  assign operand1 = bypass1 ? rd_data : regs[rs1_idx];
  assign rs2_val  = bypass2 ? rd_data : regs[rs2_idx];

  // CSR instructions take the CSR value as second operand
  assign operand2 = csr_op ? csr_rdata : rs2_val;

  // Debug port sees committed state only
  assign dbg_gpr_rdata = regs[dbg_idx];

  assign gpr_busy = rd_we;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we) begin
      if (rd_idx != '0) begin
        regs[rd_idx] <= rd_data;
      end
    end else if (dbg_gpr_we && (dbg_idx != '0)) begin
      regs[dbg_idx] <= dbg_wdata;
    end
  end

  // x0 stays zero on every read port
  a_x0_op1: assert property (
    @(posedge clk) disable iff (reset)
    (rs1_idx == '0) |-> (operand1 == '0)
  );

  a_x0_op2: assert property (
    @(posedge clk) disable iff (reset)
    (rs2_idx == '0) && !csr_op |-> (operand2 == '0)
  );

  a_x0_dbg: assert property (
    @(posedge clk) disable iff (reset)
    (dbg_idx == '0) |-> (dbg_gpr_rdata == '0)
  );

  // Debug control must hold off while the core writes back
  a_no_dual_write: assert property (
    @(posedge clk) disable iff (reset)
    !(rd_we && dbg_gpr_we)
  );

endmodule

// ==== source/regfile_top.sv ====
module regfile_top import rf_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic      clk,
  input  logic      reset,
  // Core side
  input  reg_idx_t  rs1,
  input  reg_idx_t  rs2,
  input  reg_idx_t  rd,
  input  logic      rd_we,
  input  word_t     rd_data,
  input  csr_addr_t csr_addr,
  input  logic      csr_we,
  input  word_t     csr_wdata,
  input  logic      csr_op,
  input  logic      trap_valid,
  input  word_t     trap_pc,
  input  word_t     trap_cause,
  input  logic      mret,
  output word_t     operand1,
  output word_t     operand2,
  output word_t     mtvec_out,
  output logic      mie_out,
  // APB debug port
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  word_t     pwdata,
  output logic      pready,
  output word_t     prdata,
  output logic      pslverr
);

  reg_idx_t  dbg_gpr_idx;
  csr_addr_t dbg_csr_addr;
  logic      dbg_gpr_we;
  logic      dbg_csr_we;
  word_t     dbg_wdata;
  word_t     dbg_gpr_rdata;
  word_t     dbg_csr_rdata;
  logic      dbg_csr_valid;
  word_t     csr_rdata;
  logic      csr_busy;
  logic      gpr_busy;

  int_reg_file #(
    .NUM_REGS(NUM_REGS)
  ) gpr_i (
    .clk          (clk),
    .reset        (reset),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .rd_we        (rd_we),
    .rd_data      (rd_data),
    .csr_op       (csr_op),
    .csr_rdata    (csr_rdata),
    .dbg_gpr_idx  (dbg_gpr_idx),
    .dbg_gpr_we   (dbg_gpr_we),
    .dbg_wdata    (dbg_wdata),
    .operand1     (operand1),
    .operand2     (operand2),
    .dbg_gpr_rdata(dbg_gpr_rdata),
    .gpr_busy     (gpr_busy)
  );

  csr_file csr_i (
    .clk          (clk),
    .reset        (reset),
    .csr_addr     (csr_addr),
    .csr_we       (csr_we),
    .csr_wdata    (csr_wdata),
    .trap_valid   (trap_valid),
    .trap_pc      (trap_pc),
    .trap_cause   (trap_cause),
    .mret         (mret),
    .dbg_csr_addr (dbg_csr_addr),
    .dbg_csr_we   (dbg_csr_we),
    .dbg_wdata    (dbg_wdata),
    .csr_rdata    (csr_rdata),
    .dbg_csr_rdata(dbg_csr_rdata),
    .dbg_csr_valid(dbg_csr_valid),
    .csr_busy     (csr_busy),
    .mtvec_out    (mtvec_out),
    .mie_out      (mie_out)
  );

  debug_apb_ctrl #(
    .NUM_REGS(NUM_REGS)
  ) dbg_i (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .dbg_gpr_rdata(dbg_gpr_rdata),
    .dbg_csr_rdata(dbg_csr_rdata),
    .dbg_csr_valid(dbg_csr_valid),
    .gpr_busy     (gpr_busy),
    .csr_busy     (csr_busy),
    .pready       (pready),
    .prdata       (prdata),
    .pslverr      (pslverr),
    .dbg_gpr_idx  (dbg_gpr_idx),
    .dbg_csr_addr (dbg_csr_addr),
    .dbg_gpr_we   (dbg_gpr_we),
    .dbg_csr_we   (dbg_csr_we),
    .dbg_wdata    (dbg_wdata)
  );

endmodule

// ==== source/rf_pkg.sv ====
package rf_pkg;

  // Basic widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [15:0] apb_addr_t;

  // Implemented machine CSRs
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  // mstatus fields
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // Only MIE and MPIE can be written
  localparam word_t MSTATUS_WMASK = (32'h1 << MSTATUS_MIE) | (32'h1 << MSTATUS_MPIE);

  // Debug address map, one word per register
  // GPR window covers 0x0000..0x007c
  localparam apb_addr_t APB_GPR_BASE = 16'h0000;
  // CSR window covers 0x4000..0x7ffc
  localparam apb_addr_t APB_CSR_BASE = 16'h4000;

  // Which register file a debug access lands in
  typedef enum logic [1:0] {
    GPR,
    CSR,
    NONE
  } apb_target_e;

endpackage

// ==== tests/tb_regfile_top.sv ====
module tb_regfile_top import rf_pkg::*; ();

  localparam int NUM_TESTS = 6;
  localparam int APB_BOUND = 20;

  logic      clk;
  logic      reset;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  logic      rd_we;
  logic      csr_we;
  logic      csr_op;
  logic      trap_valid;
  logic      mret;
  logic      mie_out;
  word_t     rd_data;
  word_t     csr_wdata;
  word_t     trap_pc;
  word_t     trap_cause;
  csr_addr_t csr_addr;
  word_t     operand1;
  word_t     operand2;
  word_t     mtvec_out;
  logic      psel;
  logic      penable;
  logic      pwrite;
  logic      pready;
  logic      pslverr;
  apb_addr_t paddr;
  word_t     pwdata;
  word_t     prdata;

  // Expected register contents
  word_t gpr_exp [32];
  word_t mscratch_exp;

  integer seed;
  string  cur_test;
  int     test_errors;
  int     total_errors;
  int     tests_failed;

  regfile_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Run time limit scales with the number of tests
  initial begin
    #(NUM_TESTS * 200 * 10);
    $display("Watchdog timeout after %0d cycles, the tests did not finish", NUM_TESTS * 200);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("error %s %s expected %h actual %h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s %s expected %b actual %b", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      $display("test %s failed with %0d errors", cur_test, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
  endtask

  function automatic apb_addr_t gpr_addr(input int idx);
    return APB_GPR_BASE + apb_addr_t'(idx * 4);
  endfunction

  function automatic apb_addr_t csr_apb_addr(input csr_addr_t addr);
    return APB_CSR_BASE + apb_addr_t'({addr, 2'b00});
  endfunction

  // Setup phase, then access phase held until pready
  task automatic apb_access(input logic write, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata, output logic err);
    int waited;
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    next_cycle();
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!pready && waited < APB_BOUND) begin
      waited++;
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      $display("%s: APB access to %h got no pready within %0d cycles", cur_test, addr,
               APB_BOUND);
      test_errors++;
    end
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input word_t data, output logic err);
    word_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output word_t data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  task automatic test_gpr_write_bypass();
    word_t val;
    start_test("gpr_write_bypass");
    for (int i = 1; i < 32; i++) begin
      val = $random(seed);
      next_cycle();
      rd      = reg_idx_t'(i);
      rd_we   = 1'b1;
      rd_data = val;
      rs1     = reg_idx_t'(i);
      rs2     = reg_idx_t'(i);
      @(negedge clk);
      check_word("bypass operand1", val, operand1);
      check_word("bypass operand2", val, operand2);
      next_cycle();
      rd_we = 1'b0;
      @(negedge clk);
      check_word($sformatf("x%0d operand1", i), val, operand1);
      check_word($sformatf("x%0d operand2", i), val, operand2);
      gpr_exp[i] = val;
    end
    finish_test();
  endtask

  task automatic test_x0();
    word_t data;
    logic  err;
    start_test("x0");
    next_cycle();
    rd      = '0;
    rd_we   = 1'b1;
    rd_data = 32'hdeadbeef;
    rs1     = '0;
    rs2     = '0;
    @(negedge clk);
    check_word("operand1 during write", '0, operand1);
    next_cycle();
    rd_we = 1'b0;
    @(negedge clk);
    check_word("operand1", '0, operand1);
    check_word("operand2", '0, operand2);
    apb_write(gpr_addr(0), 32'hcafef00d, err);
    check_flag("apb write pslverr", 1'b0, err);
    apb_read(gpr_addr(0), data, err);
    check_word("apb read", '0, data);
    check_flag("apb read pslverr", 1'b0, err);
    check_word("operand1 after apb", '0, operand1);
    finish_test();
  endtask

  task automatic test_csr_masks();
    csr_addr_t addrs [5] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE};
    word_t     exps [5]  = '{32'hffffffff & MSTATUS_WMASK, 32'hfffffffc, 32'hffffffff,
                             32'hfffffffc, 32'hffffffff};
    start_test("csr_masks");
    for (int i = 0; i < 5; i++) begin
      next_cycle();
      csr_addr  = addrs[i];
      csr_we    = 1'b1;
      csr_wdata = '1;
      csr_op    = 1'b0;
      next_cycle();
      csr_we = 1'b0;
      csr_op = 1'b1;
      @(negedge clk);
      check_word($sformatf("csr %h", addrs[i]), exps[i], operand2);
    end
    csr_op       = 1'b0;
    mscratch_exp = '1;
    check_flag("mie_out", 1'b1, mie_out);
    check_word("mtvec_out", 32'hfffffffc, mtvec_out);
    finish_test();
  endtask

  task automatic test_trap_mret();
    word_t pc;
    word_t cause;
    start_test("trap_mret");
    pc    = $random(seed);
    cause = $random(seed);
    next_cycle();
    csr_addr  = CSR_MSTATUS;
    csr_we    = 1'b1;
    csr_wdata = 32'h1 << MSTATUS_MIE;
    next_cycle();
    csr_we     = 1'b0;
    trap_valid = 1'b1;
    trap_pc    = pc;
    trap_cause = cause;
    @(negedge clk);
    check_flag("mie before trap", 1'b1, mie_out);
    next_cycle();
    trap_valid = 1'b0;
    csr_op     = 1'b1;
    csr_addr   = CSR_MEPC;
    @(negedge clk);
    check_word("mepc", pc & ~32'h3, operand2);
    check_flag("mie after trap", 1'b0, mie_out);
    next_cycle();
    csr_addr = CSR_MCAUSE;
    @(negedge clk);
    check_word("mcause", cause, operand2);
    next_cycle();
    csr_addr = CSR_MSTATUS;
    @(negedge clk);
    check_flag("mpie after trap", 1'b1, operand2[MSTATUS_MPIE]);
    next_cycle();
    csr_op = 1'b0;
    mret   = 1'b1;
    next_cycle();
    mret = 1'b0;
    @(negedge clk);
    check_flag("mie after mret", 1'b1, mie_out);
    finish_test();
  endtask

  task automatic test_apb_conflict();
    word_t gpr_val;
    word_t csr_val;
    word_t data;
    logic  err;
    start_test("apb_conflict");
    gpr_val = $random(seed);
    csr_val = $random(seed);
    next_cycle();
    rd      = 5'd5;
    rd_data = $random(seed);
    rd_we   = 1'b1;
    gpr_exp[5] = rd_data;
    fork
      apb_write(gpr_addr(7), gpr_val, err);
      begin
        repeat (4) begin
          @(negedge clk);
          check_flag("pready while rd_we", 1'b0, pready);
        end
        next_cycle();
        rd_we = 1'b0;
      end
    join
    check_flag("gpr write pslverr", 1'b0, err);
    apb_read(gpr_addr(7), data, err);
    check_word("x7 over apb", gpr_val, data);
    // Core keeps writing mtvec while the debugger targets mscratch
    next_cycle();
    csr_addr  = CSR_MTVEC;
    csr_wdata = 32'h100;
    csr_we    = 1'b1;
    fork
      apb_write(csr_apb_addr(CSR_MSCRATCH), csr_val, err);
      begin
        repeat (4) begin
          @(negedge clk);
          check_flag("pready while csr_we", 1'b0, pready);
        end
        next_cycle();
        csr_we = 1'b0;
      end
    join
    check_flag("csr write pslverr", 1'b0, err);
    apb_read(csr_apb_addr(CSR_MSCRATCH), data, err);
    check_word("mscratch over apb", csr_val, data);
    check_word("mtvec_out", 32'h100, mtvec_out);
    mscratch_exp = csr_val;
    next_cycle();
    rd      = 5'd7;
    rd_data = $random(seed);
    rd_we   = 1'b1;
    gpr_exp[7] = rd_data;
    next_cycle();
    rd_we = 1'b0;
    apb_read(gpr_addr(7), data, err);
    check_word("core write over apb", gpr_exp[7], data);
    finish_test();
  endtask

  task automatic test_apb_errors();
    // Unmapped, unmapped, misaligned onto x1, misa
    apb_addr_t bad [4] = '{16'h1000, 16'h8000, 16'h0006, 16'h4c04};
    word_t     data;
    logic      err;
    start_test("apb_errors");
    for (int i = 0; i < 4; i++) begin
      apb_write(bad[i], 32'h5a5a5a5a, err);
      check_flag($sformatf("write %h pslverr", bad[i]), 1'b1, err);
      apb_read(bad[i], data, err);
      check_flag($sformatf("read %h pslverr", bad[i]), 1'b1, err);
    end
    apb_read(csr_apb_addr(CSR_MSCRATCH), data, err);
    check_word("mscratch", mscratch_exp, data);
    check_word("mtvec", 32'h100, mtvec_out);
    for (int i = 0; i < 32; i++) begin
      next_cycle();
      rs1 = reg_idx_t'(i);
      @(negedge clk);
      check_word($sformatf("x%0d", i), gpr_exp[i], operand1);
    end
    finish_test();
  endtask

  initial begin
    seed = 32'hea49;
    reset = 1'b1;
    {rs1, rs2, rd, rd_we, rd_data, csr_addr, csr_we, csr_wdata, csr_op} = '0;
    {trap_valid, trap_pc, trap_cause, mret} = '0;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    mscratch_exp = '0;
    total_errors = 0;
    tests_failed = 0;
    for (int i = 0; i < 32; i++) begin
      gpr_exp[i] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    test_gpr_write_bypass();
    test_x0();
    test_csr_masks();
    test_trap_mret();
    test_apb_conflict();
    test_apb_errors();
    $display("tests %0d, failed tests %0d, errors %0d", NUM_TESTS, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
